// File: clock_pkg.sv
package clock_pkg;

    // Every time unit shares one count width, wide enough for the largest modulus
    localparam int COUNT_W = 6;

    localparam int SEC_MOD  = 60;
    localparam int MIN_MOD  = 60;
    localparam int HOUR_MOD = 24;

    // Clock cycles per one-second strobe
    // Silicon would use the real oscillator rate here, e.g. 50 million
    localparam int TICKS_PER_SEC = 5;

    // Divider counter width, sized so that TICKS_PER_SEC itself fits
    localparam int TICK_CNT_W = $clog2(TICKS_PER_SEC + 1);

    // Decoded result of the increase and decrease edge detectors
    typedef enum logic [1:0] {
        ADJ_NONE = 2'd0,
        ADJ_UP   = 2'd1,
        ADJ_DOWN = 2'd2
    } adjust_op_e;

endpackage

// File: clock_unit_if.sv
`timescale 1ns/1ps

interface clock_unit_if;

    // Advance strobe from the previous stage of the carry chain
    logic step;

    // Adjust levels, acted on once per rising edge
    logic increase;
    logic decrease;

    // Count-enable level
    logic enable;

    logic [clock_pkg::COUNT_W-1:0] count;

    // One-cycle strobe on a counted wrap
    logic carry;

    modport unit (
        input  step,
        input  increase,
        input  decrease,
        input  enable,
        output count,
        output carry
    );

    modport host (
        output step,
        output increase,
        output decrease,
        output enable,
        input  count,
        input  carry
    );

endinterface

// File: digital_clock_asserts.sv
`timescale 1ns/1ps

module digital_clock_asserts (
    input logic                          clk,
    input logic                          rst_n,
    input logic [clock_pkg::COUNT_W-1:0] cnt_s,
    input logic [clock_pkg::COUNT_W-1:0] cnt_mi,
    input logic [clock_pkg::COUNT_W-1:0] cnt_h,
    input logic                          pulse_1mi,
    input logic                          pulse_1h,
    input logic                          pulse_1d
);

    // A wrap always leaves the top value, so no carry can repeat on the next edge
    assert property (@(posedge clk) disable iff (!rst_n) pulse_1mi |=> !pulse_1mi)
        else $error("pulse_1mi stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n) pulse_1h |=> !pulse_1h)
        else $error("pulse_1h stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n) pulse_1d |=> !pulse_1d)
        else $error("pulse_1d stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n) int'(cnt_s) < clock_pkg::SEC_MOD)
        else $error("cnt_s left its range");

    assert property (@(posedge clk) disable iff (!rst_n) int'(cnt_mi) < clock_pkg::MIN_MOD)
        else $error("cnt_mi left its range");

    assert property (@(posedge clk) disable iff (!rst_n) int'(cnt_h) < clock_pkg::HOUR_MOD)
        else $error("cnt_h left its range");

endmodule

bind digital_clock_top digital_clock_asserts digital_clock_asserts_i (.*);

// File: digital_clock_top.sv
`timescale 1ns/1ps

module digital_clock_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          enable_pulse_1s,

    input  logic                          increase_s,
    input  logic                          decrease_s,
    input  logic                          enable_cnt_s,
    output logic [clock_pkg::COUNT_W-1:0] cnt_s,
    output logic                          pulse_1mi,

    input  logic                          increase_mi,
    input  logic                          decrease_mi,
    input  logic                          enable_cnt_mi,
    output logic [clock_pkg::COUNT_W-1:0] cnt_mi,
    output logic                          pulse_1h,

    input  logic                          increase_h,
    input  logic                          decrease_h,
    input  logic                          enable_cnt_h,
    output logic [clock_pkg::COUNT_W-1:0] cnt_h,
    output logic                          pulse_1d
);

    logic tick;

    clock_unit_if sec_if ();
    clock_unit_if min_if ();
    clock_unit_if hour_if ();

    tick_divider tick_divider_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .enable_pulse_1s (enable_pulse_1s),
        .tick            (tick)
    );

    // Seconds unit, stepped by the one-second strobe
    assign sec_if.step     = tick;
    assign sec_if.increase = increase_s;
    assign sec_if.decrease = decrease_s;
    assign sec_if.enable   = enable_cnt_s;
    assign cnt_s           = sec_if.count;
    assign pulse_1mi       = sec_if.carry;

    time_unit_counter #(
        .MODULUS (clock_pkg::SEC_MOD)
    ) sec_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .unit  (sec_if.unit)
    );

    // Minutes unit, stepped by the seconds wrap
    assign min_if.step     = sec_if.carry;
    assign min_if.increase = increase_mi;
    assign min_if.decrease = decrease_mi;
    assign min_if.enable   = enable_cnt_mi;
    assign cnt_mi          = min_if.count;
    assign pulse_1h        = min_if.carry;

    time_unit_counter #(
        .MODULUS (clock_pkg::MIN_MOD)
    ) min_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .unit  (min_if.unit)
    );

    // Hours unit, stepped by the minutes wrap
    assign hour_if.step     = min_if.carry;
    assign hour_if.increase = increase_h;
    assign hour_if.decrease = decrease_h;
    assign hour_if.enable   = enable_cnt_h;
    assign cnt_h            = hour_if.count;
    assign pulse_1d         = hour_if.carry;

    time_unit_counter #(
        .MODULUS (clock_pkg::HOUR_MOD)
    ) hour_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .unit  (hour_if.unit)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the simulation stops on an error.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_digital_clock \
    -Mdir obj_dir \
    -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_digital_clock
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0

// File: sim.f
clock_pkg.sv
clock_unit_if.sv
tick_divider.sv
time_unit_counter.sv
digital_clock_top.sv
digital_clock_asserts.sv
tb_digital_clock.sv

// File: tb_digital_clock.sv
`timescale 1ns/1ps

module tb_digital_clock;

    localparam int T = clock_pkg::TICKS_PER_SEC;

    logic clk;
    logic rst_n;
    logic enable_pulse_1s;
    logic increase_s;
    logic decrease_s;
    logic enable_cnt_s;
    logic increase_mi;
    logic decrease_mi;
    logic enable_cnt_mi;
    logic increase_h;
    logic decrease_h;
    logic enable_cnt_h;
    logic [clock_pkg::COUNT_W-1:0] cnt_s;
    logic [clock_pkg::COUNT_W-1:0] cnt_mi;
    logic [clock_pkg::COUNT_W-1:0] cnt_h;
    logic pulse_1mi;
    logic pulse_1h;
    logic pulse_1d;

    // Reference model state, one set per time unit plus the divider
    int   m_cnt_s;
    int   m_cnt_mi;
    int   m_cnt_h;
    logic m_inc_s;
    logic m_dec_s;
    logic m_inc_mi;
    logic m_dec_mi;
    logic m_inc_h;
    logic m_dec_h;
    int   m_cycle;
    logic m_tick;

    logic [15:0] lfsr_state = 16'd96;

    digital_clock_top digital_clock_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR at time %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what, input int cycles);
        $display("Timed out after %0d cycles waiting for %s", cycles, what);
        $display("Simulation FAILED");
        $fatal(1, "Wait limit exceeded");
    endtask

    // Next count in the low bits, carry in the top bit
    function automatic logic [clock_pkg::COUNT_W:0] model_unit(
        input int count, input int modulus, input logic step, input logic enable,
        input logic inc_prev, input logic inc_now, input logic dec_prev, input logic dec_now);
        clock_pkg::adjust_op_e op;
        int   next_count;
        logic carry;
        op = clock_pkg::ADJ_NONE;
        if (inc_now && !inc_prev && !(dec_now && !dec_prev)) begin
            op = clock_pkg::ADJ_UP;
        end else if (dec_now && !dec_prev && !(inc_now && !inc_prev)) begin
            op = clock_pkg::ADJ_DOWN;
        end
        next_count = count;
        carry = 1'b0;
        case (op)
            clock_pkg::ADJ_UP: next_count = (count + 1) % modulus;
            clock_pkg::ADJ_DOWN: next_count = (count + modulus - 1) % modulus;
            default: begin
                if (enable && step) begin
                    carry = (count == modulus - 1);
                    next_count = (count + 1) % modulus;
                end
            end
        endcase
        return {carry, clock_pkg::COUNT_W'(next_count)};
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Returns 1 only when n freshly drawn bits are all set
    task automatic draw_rare(input int n, output logic hit);
        int i;
        hit = 1'b1;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            hit = hit & lfsr_state[0];
        end
    endtask

    always @(posedge clk) begin : compare_proc
        logic [clock_pkg::COUNT_W:0] nxt_s;
        logic [clock_pkg::COUNT_W:0] nxt_mi;
        logic [clock_pkg::COUNT_W:0] nxt_h;
        if (!rst_n) begin
            m_cnt_s = 0;
            m_cnt_mi = 0;
            m_cnt_h = 0;
            {m_inc_s, m_dec_s, m_inc_mi, m_dec_mi, m_inc_h, m_dec_h} = '0;
            m_cycle = 0;
            m_tick = 1'b0;
        end else begin
            nxt_s = model_unit(m_cnt_s, clock_pkg::SEC_MOD, m_tick, enable_cnt_s,
                               m_inc_s, increase_s, m_dec_s, decrease_s);
            nxt_mi = model_unit(m_cnt_mi, clock_pkg::MIN_MOD, nxt_s[clock_pkg::COUNT_W],
                                enable_cnt_mi, m_inc_mi, increase_mi, m_dec_mi, decrease_mi);
            nxt_h = model_unit(m_cnt_h, clock_pkg::HOUR_MOD, nxt_mi[clock_pkg::COUNT_W],
                               enable_cnt_h, m_inc_h, increase_h, m_dec_h, decrease_h);
            check_value("tick", int'(m_tick), int'(digital_clock_top_i.tick));
            check_value("cnt_s", m_cnt_s, int'(cnt_s));
            check_value("cnt_mi", m_cnt_mi, int'(cnt_mi));
            check_value("cnt_h", m_cnt_h, int'(cnt_h));
            check_value("pulse_1mi", int'(nxt_s[clock_pkg::COUNT_W]), int'(pulse_1mi));
            check_value("pulse_1h", int'(nxt_mi[clock_pkg::COUNT_W]), int'(pulse_1h));
            check_value("pulse_1d", int'(nxt_h[clock_pkg::COUNT_W]), int'(pulse_1d));
            m_cnt_s = int'(nxt_s[clock_pkg::COUNT_W-1:0]);
            m_cnt_mi = int'(nxt_mi[clock_pkg::COUNT_W-1:0]);
            m_cnt_h = int'(nxt_h[clock_pkg::COUNT_W-1:0]);
            {m_inc_s, m_dec_s} = {increase_s, decrease_s};
            {m_inc_mi, m_dec_mi} = {increase_mi, decrease_mi};
            {m_inc_h, m_dec_h} = {increase_h, decrease_h};
            // Divider follows the registered terminal-count rule
            m_tick = enable_pulse_1s && (m_cycle == T - 1);
            if (enable_pulse_1s) begin
                m_cycle = (m_cycle == T - 1) ? 0 : m_cycle + 1;
            end
        end
    end

    task automatic idle_cycles(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        {enable_pulse_1s, enable_cnt_s, enable_cnt_mi, enable_cnt_h} = '0;
        {increase_s, decrease_s, increase_mi, decrease_mi, increase_h, decrease_h} = '0;
        idle_cycles(5);
        rst_n = 1'b1;
    endtask

    task automatic set_adjust(input int which, input logic up, input logic down);
        case (which)
            0: {increase_s, decrease_s} = {up, down};
            1: {increase_mi, decrease_mi} = {up, down};
            default: {increase_h, decrease_h} = {up, down};
        endcase
    endtask

    // One rising edge on the chosen levels, then release
    task automatic adjust_unit(input int which, input logic up, input logic down);
        @(negedge clk);
        set_adjust(which, up, down);
        @(negedge clk);
        set_adjust(which, 1'b0, 1'b0);
    endtask

    task automatic wait_for_pulse(input int which, input int limit);
        int   waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            waited++;
            case (which)
                0: seen = pulse_1mi;
                1: seen = pulse_1h;
                default: seen = pulse_1d;
            endcase
            if (!seen && waited >= limit) begin
                report_timeout("a carry pulse", waited);
            end
        end
    endtask

    task automatic wait_for_sec_change(input int limit, output int waited);
        int start_value;
        start_value = int'(cnt_s);
        waited = 0;
        while (int'(cnt_s) == start_value) begin
            @(negedge clk);
            waited++;
            if (int'(cnt_s) == start_value && waited >= limit) begin
                report_timeout("cnt_s to advance", waited);
            end
        end
    endtask

    initial begin : stimulus
        int   period;
        int   i;
        logic flip;
        rst_n = 1'b0;
        {enable_pulse_1s, enable_cnt_s, enable_cnt_mi, enable_cnt_h} = '0;
        {increase_s, decrease_s, increase_mi, decrease_mi, increase_h, decrease_h} = '0;
        apply_reset();

        // Counting enabled but no second strobe
        {enable_cnt_s, enable_cnt_mi, enable_cnt_h} = 3'b111;
        idle_cycles(4 * T);
        check_value("cnt_s", 0, int'(cnt_s));

        enable_pulse_1s = 1'b1;
        wait_for_sec_change(2 * T + 2, period);
        wait_for_sec_change(2 * T + 2, period);
        check_value("seconds period", T, period);
        wait_for_pulse(0, 61 * T + 4);
        check_value("cnt_s", 59, int'(cnt_s));
        @(negedge clk);
        check_value("cnt_s", 0, int'(cnt_s));
        check_value("cnt_mi", 1, int'(cnt_mi));

        // Manual adjusts with counting off
        apply_reset();
        adjust_unit(0, 1'b0, 1'b1);
        check_value("cnt_s", 59, int'(cnt_s));
        adjust_unit(0, 1'b1, 1'b0);
        check_value("cnt_s", 0, int'(cnt_s));
        adjust_unit(0, 1'b1, 1'b1);
        check_value("cnt_s", 0, int'(cnt_s));
        @(negedge clk);
        increase_s = 1'b1;
        idle_cycles(4);
        increase_s = 1'b0;
        @(negedge clk);
        check_value("cnt_s", 1, int'(cnt_s));
        adjust_unit(1, 1'b0, 1'b1);
        check_value("cnt_mi", 59, int'(cnt_mi));
        adjust_unit(1, 1'b1, 1'b0);
        check_value("cnt_mi", 0, int'(cnt_mi));
        adjust_unit(2, 1'b0, 1'b1);
        check_value("cnt_h", 23, int'(cnt_h));
        adjust_unit(2, 1'b1, 1'b0);
        check_value("cnt_h", 0, int'(cnt_h));

        // Set 23:59:58 and let the day roll over
        apply_reset();
        adjust_unit(2, 1'b0, 1'b1);
        adjust_unit(1, 1'b0, 1'b1);
        adjust_unit(0, 1'b0, 1'b1);
        adjust_unit(0, 1'b0, 1'b1);
        check_value("cnt_s", 58, int'(cnt_s));
        {enable_pulse_1s, enable_cnt_s, enable_cnt_mi, enable_cnt_h} = 4'b1111;
        wait_for_pulse(2, 3 * T + 4);
        check_value("pulse_1mi", 1, int'(pulse_1mi));
        check_value("pulse_1h", 1, int'(pulse_1h));
        @(negedge clk);
        check_value("cnt_s", 0, int'(cnt_s));
        check_value("cnt_mi", 0, int'(cnt_mi));
        check_value("cnt_h", 0, int'(cnt_h));

        // Minutes frozen at their top value while seconds wrap
        enable_cnt_mi = 1'b0;
        adjust_unit(1, 1'b0, 1'b1);
        check_value("cnt_mi", 59, int'(cnt_mi));
        wait_for_pulse(0, 61 * T + 4);
        check_value("pulse_1h", 0, int'(pulse_1h));
        @(negedge clk);
        check_value("cnt_mi", 59, int'(cnt_mi));
        enable_cnt_mi = 1'b1;

        // Random adjusts and enable toggles, checked every edge by the model
        for (i = 0; i < 3000; i++) begin
            @(negedge clk);
            draw_rare(3, increase_s);
            draw_rare(3, decrease_s);
            draw_rare(3, increase_mi);
            draw_rare(3, decrease_mi);
            draw_rare(3, increase_h);
            draw_rare(3, decrease_h);
            draw_rare(4, flip);
            enable_pulse_1s = enable_pulse_1s ^ flip;
            draw_rare(4, flip);
            enable_cnt_s = enable_cnt_s ^ flip;
            draw_rare(4, flip);
            enable_cnt_mi = enable_cnt_mi ^ flip;
            draw_rare(4, flip);
            enable_cnt_h = enable_cnt_h ^ flip;
        end
        idle_cycles(4);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: tick_divider.sv
`timescale 1ns/1ps

module tick_divider (
    input  logic clk,
    input  logic rst_n,
    input  logic enable_pulse_1s,
    output logic tick
);

    logic [clock_pkg::TICK_CNT_W-1:0] cycle_cnt;
    logic                             last_cycle;

    assign last_cycle =
        (cycle_cnt == clock_pkg::TICK_CNT_W'(clock_pkg::TICKS_PER_SEC - 1));

    // The cycle counter only moves while enabled, so a pause keeps the
    // phase of the current second intact
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (enable_pulse_1s) begin
            if (last_cycle) begin
                cycle_cnt <= '0;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    // Registered strobe, high for the cycle after the counter leaves its
    // terminal value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick <= 1'b0;
        end else begin
            tick <= enable_pulse_1s && last_cycle;
        end
    end

endmodule

// File: time_unit_counter.sv
`timescale 1ns/1ps

module time_unit_counter #(
    parameter int MODULUS = 60
) (
    input logic        clk,
    input logic        rst_n,
    clock_unit_if.unit unit
);

    logic                  increase_q;
    logic                  decrease_q;
    logic                  increase_rise;
    logic                  decrease_rise;
    clock_pkg::adjust_op_e adjust_op;
    logic                  at_top;
    logic                  at_bottom;
    logic                  counted_step;

    // Previous levels of the adjust inputs for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            increase_q <= 1'b0;
            decrease_q <= 1'b0;
        end else begin
            increase_q <= unit.increase;
            decrease_q <= unit.decrease;
        end
    end

    assign increase_rise = unit.increase && !increase_q;
    assign decrease_rise = unit.decrease && !decrease_q;

    // Two edges in the same cycle cancel each other out
    always_comb begin
        if (increase_rise && !decrease_rise) begin
            adjust_op = clock_pkg::ADJ_UP;
        end else if (decrease_rise && !increase_rise) begin
            adjust_op = clock_pkg::ADJ_DOWN;
        end else begin
            adjust_op = clock_pkg::ADJ_NONE;
        end
    end

    assign at_top    = (unit.count == clock_pkg::COUNT_W'(MODULUS - 1));
    assign at_bottom = (unit.count == '0);

    // A step only counts when no adjust claims the same cycle
    assign counted_step = unit.enable && unit.step && (adjust_op == clock_pkg::ADJ_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unit.count <= '0;
        end else begin
            unique case (adjust_op)
                clock_pkg::ADJ_UP: begin
                    unit.count <= at_top ? '0 : unit.count + 1'b1;
                end
                clock_pkg::ADJ_DOWN: begin
                    unit.count <= at_bottom ? clock_pkg::COUNT_W'(MODULUS - 1)
                                            : unit.count - 1'b1;
                end
                default: begin
                    if (counted_step) begin
                        unit.count <= at_top ? '0 : unit.count + 1'b1;
                    end
                end
            endcase
        end
    end

    // Carry is combinational so a full wrap ripples through all units on one edge
    assign unit.carry = counted_step && at_top;

endmodule
